//--- common/rr_pkg.sv
`default_nettype none

package rr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Channel widths and payloads
  //////////////////////////////////////////////////////////////////////

  // Register-write channel address
  localparam int CHAN_A_ADDR_W = 16;
  // Data word on either channel
  localparam int CHAN_DATA_W = 32;
  // Channels merged into one log word
  localparam int NUM_CHANNELS = 2;

  // Channel A, register write: address on top, data below (48 bits)
  typedef struct packed {
    logic [CHAN_A_ADDR_W-1:0] addr;
    logic [CHAN_DATA_W-1:0]   data;
  } chan_a_req_t;

  // Channel B, doorbell (32 bits)
  typedef struct packed {
    logic [CHAN_DATA_W-1:0] data;
  } chan_b_req_t;

  //////////////////////////////////////////////////////////////////////
  // Log word layout
  //////////////////////////////////////////////////////////////////////

  // Bit positions inside the valid field
  localparam int VALID_A = 1;
  localparam int VALID_B = 0;

  // 82 bits: valid[81:80], chan A [79:32], chan B [31:0]
  // Idle channel payload is all zeros
  typedef struct packed {
    logic [NUM_CHANNELS-1:0] valid;
    chan_a_req_t             a;
    chan_b_req_t             b;
  } log_word_t;

  //////////////////////////////////////////////////////////////////////
  // Mode and configuration port
  //////////////////////////////////////////////////////////////////////

  // Bit 0 record, bit 1 replay
  typedef struct packed {
    logic replay_en;
    logic record_en;
  } rr_mode_t;

  localparam int MODE_W = $bits(rr_mode_t);

  localparam int CFG_ADDR_W = 4;
  localparam int CFG_DATA_W = 32;
  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MODE = 4'd0;
  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_COUNT = 4'd1;

  // Recorded word counter
  localparam int COUNT_W = 32;

  // Stages between the mode register and its consumers
  localparam int MODE_PIPE_STAGES = 4;

endpackage

`default_nettype wire

//--- design/rr_mode_csr.sv
`default_nettype none

module rr_mode_csr (
  input  wire logic                          i_clk,
  input  wire logic                          i_rst,
  // Host configuration strobes
  input  wire logic                          i_cfg_we,
  input  wire logic                          i_cfg_re,
  input  wire logic [rr_pkg::CFG_ADDR_W-1:0] i_cfg_addr,
  input  wire logic [rr_pkg::CFG_DATA_W-1:0] i_cfg_wdata,
  // One pulse per emitted log word
  input  wire logic                          i_word_logged,
  output      logic                          o_cfg_rvalid,
  output      logic [rr_pkg::CFG_DATA_W-1:0] o_cfg_rdata,
  // Aligned mode seen by every channel
  output      rr_pkg::rr_mode_t              o_mode
);

  import rr_pkg::*;

  // Mode as written by the host
  rr_mode_t mode_q;
  // Alignment shift, stage 0 nearest the register
  rr_mode_t mode_pipe [MODE_PIPE_STAGES];
  // Log words recorded since reset
  logic [COUNT_W-1:0] count_q;
  // Read mux ahead of the output register
  logic [CFG_DATA_W-1:0] rdata_d;

  //////////////////////////////////////////////////////////////////////
  // Mode register and alignment pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mode_q <= '0;
    end else if (i_cfg_we && (i_cfg_addr == CFG_ADDR_MODE)) begin
      // Only the low mode bits are kept
      mode_q <= rr_mode_t'(i_cfg_wdata[MODE_W-1:0]);
    end
  end

  // Fixed depth so every consumer flips in the same cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < MODE_PIPE_STAGES; i++) begin
        mode_pipe[i] <= '0;
      end
    end else begin
      mode_pipe[0] <= mode_q;
      for (int i = 1; i < MODE_PIPE_STAGES; i++) begin
        mode_pipe[i] <= mode_pipe[i-1];
      end
    end
  end

  assign o_mode = mode_pipe[MODE_PIPE_STAGES-1];

  //////////////////////////////////////////////////////////////////////
  // Word counter and readback
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count_q <= '0;
    end else if (i_word_logged) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Unknown addresses read as zero
  always_comb begin
    rdata_d = '0;
    case (i_cfg_addr)
      CFG_ADDR_MODE:  rdata_d = {{(CFG_DATA_W-MODE_W){1'b0}}, mode_q};
      CFG_ADDR_COUNT: rdata_d = count_q;
      default:        rdata_d = '0;
    endcase
  end

  // Read data one cycle after the strobe
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_cfg_rvalid <= 1'b0;
    end else begin
      o_cfg_rvalid <= i_cfg_re;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_cfg_re) begin
      o_cfg_rdata <= rdata_d;
    end
  end

endmodule

`default_nettype wire

//--- design/rr_chan_sel.sv
`default_nettype none

module rr_chan_sel #(
  parameter type payload_t = logic
) (
  input  wire logic i_clk,
  input  wire logic i_rst,
  // Aligned replay mode bit
  input  wire logic i_replay_en,
  // Live shell traffic
  input  wire logic i_sh_valid,
  input  payload_t  i_sh_req,
  // Traffic from the trace decoder
  input  wire logic i_rp_valid,
  input  payload_t  i_rp_req,
  // Toward the user side
  output      logic o_valid,
  output payload_t  o_req
);

  // Chosen side before the output register
  logic     sel_valid;
  payload_t sel_req;

  // Strobe of the other side is simply dropped
  assign sel_valid = i_replay_en ? i_rp_valid : i_sh_valid;
  assign sel_req   = i_replay_en ? i_rp_req : i_sh_req;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= sel_valid;
    end
  end

  // Payload held between strobes
  always_ff @(posedge i_clk) begin
    if (sel_valid) begin
      o_req <= sel_req;
    end
  end

endmodule

`default_nettype wire

//--- recorder/rr_log_packer.sv
`default_nettype none

module rr_log_packer (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  // Aligned record mode bit
  input  wire logic                i_record_en,
  // CL-side strobes of both channels
  input  wire logic                i_a_valid,
  input  rr_pkg::chan_a_req_t      i_a_req,
  input  wire logic                i_b_valid,
  input  rr_pkg::chan_b_req_t      i_b_req,
  // Log stream, one word per active cycle
  output      logic                o_log_valid,
  output      rr_pkg::log_word_t   o_log_word,
  // Count pulse toward the CSR block
  output      logic                o_word_logged
);

  import rr_pkg::*;

  logic      capture;
  log_word_t word_d;
  logic      log_valid_q;

  //////////////////////////////////////////////////////////////////////
  // Word assembly
  //////////////////////////////////////////////////////////////////////

  // Any channel active while recording
  assign capture = i_record_en && (i_a_valid || i_b_valid);

  always_comb begin
    word_d = '0;
    word_d.valid[VALID_A] = i_a_valid;
    word_d.valid[VALID_B] = i_b_valid;
    // Idle payloads stay zero so replay sees a clean word
    if (i_a_valid) begin
      word_d.a = i_a_req;
    end
    if (i_b_valid) begin
      word_d.b = i_b_req;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      log_valid_q <= 1'b0;
    end else begin
      log_valid_q <= capture;
    end
  end

  always_ff @(posedge i_clk) begin
    if (capture) begin
      o_log_word <= word_d;
    end
  end

  assign o_log_valid = log_valid_q;
  // Every emitted word is counted
  assign o_word_logged = log_valid_q;

endmodule

`default_nettype wire

//--- replayer/rr_trace_decoder.sv
`default_nettype none

module rr_trace_decoder (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  // Aligned replay mode bit
  input  wire logic            i_replay_en,
  // Packed replay stream
  input  wire logic            i_rply_valid,
  input  rr_pkg::log_word_t    i_rply_word,
  // Per-channel replay strobes
  output      logic            o_a_valid,
  output rr_pkg::chan_a_req_t  o_a_req,
  output      logic            o_b_valid,
  output rr_pkg::chan_b_req_t  o_b_req
);

  import rr_pkg::*;

  // Accepted word and its strobe
  logic      take;
  logic      word_vld_q;
  log_word_t word_q;

  // Words arriving outside replay are dropped
  assign take = i_replay_en && i_rply_valid;

  //////////////////////////////////////////////////////////////////////
  // Input register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      word_vld_q <= 1'b0;
    end else begin
      word_vld_q <= take;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      word_q <= i_rply_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Split into channels
  //////////////////////////////////////////////////////////////////////

  // Strobe per channel from its valid bit
  assign o_a_valid = word_vld_q && word_q.valid[VALID_A];
  assign o_b_valid = word_vld_q && word_q.valid[VALID_B];

  // Payload fields pass as stored
  assign o_a_req = word_q.a;
  assign o_b_req = word_q.b;

endmodule

`default_nettype wire

//--- design/rr_top.sv
`default_nettype none

module rr_top (
  input  wire logic                          i_clk,
  input  wire logic                          i_rst,
  // Shell side, channel A register writes
  input  wire logic                          i_sh_a_valid,
  input  rr_pkg::chan_a_req_t                i_sh_a_req,
  // Shell side, channel B doorbells
  input  wire logic                          i_sh_b_valid,
  input  rr_pkg::chan_b_req_t                i_sh_b_req,
  // Replay source
  input  wire logic                          i_rply_valid,
  input  rr_pkg::log_word_t                  i_rply_word,
  // Host configuration port
  input  wire logic                          i_cfg_we,
  input  wire logic                          i_cfg_re,
  input  wire logic [rr_pkg::CFG_ADDR_W-1:0] i_cfg_addr,
  input  wire logic [rr_pkg::CFG_DATA_W-1:0] i_cfg_wdata,
  // User side
  output      logic                          o_cl_a_valid,
  output rr_pkg::chan_a_req_t                o_cl_a_req,
  output      logic                          o_cl_b_valid,
  output rr_pkg::chan_b_req_t                o_cl_b_req,
  // Log stream
  output      logic                          o_log_valid,
  output rr_pkg::log_word_t                  o_log_word,
  // Configuration readback
  output      logic                          o_cfg_rvalid,
  output      logic [rr_pkg::CFG_DATA_W-1:0] o_cfg_rdata
);

  import rr_pkg::*;

  // Aligned mode, shared by all channels
  rr_mode_t    mode;
  logic        word_logged;
  // Decoded replay traffic per channel
  logic        rp_a_valid;
  chan_a_req_t rp_a_req;
  logic        rp_b_valid;
  chan_b_req_t rp_b_req;

  //////////////////////////////////////////////////////////////////////
  // Mode registers
  //////////////////////////////////////////////////////////////////////

  rr_mode_csr csr (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_cfg_we      (i_cfg_we),
    .i_cfg_re      (i_cfg_re),
    .i_cfg_addr    (i_cfg_addr),
    .i_cfg_wdata   (i_cfg_wdata),
    .i_word_logged (word_logged),
    .o_cfg_rvalid  (o_cfg_rvalid),
    .o_cfg_rdata   (o_cfg_rdata),
    .o_mode        (mode)
  );

  //////////////////////////////////////////////////////////////////////
  // Shell or replay, per channel
  //////////////////////////////////////////////////////////////////////

  rr_chan_sel #(.payload_t(chan_a_req_t)) sel_a (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_replay_en (mode.replay_en),
    .i_sh_valid  (i_sh_a_valid),
    .i_sh_req    (i_sh_a_req),
    .i_rp_valid  (rp_a_valid),
    .i_rp_req    (rp_a_req),
    .o_valid     (o_cl_a_valid),
    .o_req       (o_cl_a_req)
  );

  rr_chan_sel #(.payload_t(chan_b_req_t)) sel_b (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_replay_en (mode.replay_en),
    .i_sh_valid  (i_sh_b_valid),
    .i_sh_req    (i_sh_b_req),
    .i_rp_valid  (rp_b_valid),
    .i_rp_req    (rp_b_req),
    .o_valid     (o_cl_b_valid),
    .o_req       (o_cl_b_req)
  );

  // Packer watches what the user side actually gets
  rr_log_packer packer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_record_en   (mode.record_en),
    .i_a_valid     (o_cl_a_valid),
    .i_a_req       (o_cl_a_req),
    .i_b_valid     (o_cl_b_valid),
    .i_b_req       (o_cl_b_req),
    .o_log_valid   (o_log_valid),
    .o_log_word    (o_log_word),
    .o_word_logged (word_logged)
  );

  // Replay words back into channel strobes
  rr_trace_decoder decoder (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_replay_en  (mode.replay_en),
    .i_rply_valid (i_rply_valid),
    .i_rply_word  (i_rply_word),
    .o_a_valid    (rp_a_valid),
    .o_a_req      (rp_a_req),
    .o_b_valid    (rp_b_valid),
    .o_b_req      (rp_b_req)
  );

endmodule

`default_nettype wire

//--- verif/rr_checker.sv
`default_nettype none

module rr_checker (
  input  wire logic                          i_clk,
  input  wire logic                          i_rst,
  // Current test phase from the stimulus side
  input  wire logic [2:0]                    i_phase,
  // DUT inputs
  input  wire logic                          i_sh_a_valid,
  input  rr_pkg::chan_a_req_t                i_sh_a_req,
  input  wire logic                          i_sh_b_valid,
  input  rr_pkg::chan_b_req_t                i_sh_b_req,
  input  wire logic                          i_cfg_we,
  input  wire logic                          i_cfg_re,
  input  wire logic [rr_pkg::CFG_ADDR_W-1:0] i_cfg_addr,
  input  wire logic [rr_pkg::CFG_DATA_W-1:0] i_cfg_wdata,
  // DUT outputs
  input  wire logic                          i_cl_a_valid,
  input  rr_pkg::chan_a_req_t                i_cl_a_req,
  input  wire logic                          i_cl_b_valid,
  input  rr_pkg::chan_b_req_t                i_cl_b_req,
  input  wire logic                          i_log_valid,
  input  rr_pkg::log_word_t                  i_log_word,
  input  wire logic                          i_cfg_rvalid,
  input  wire logic [rr_pkg::CFG_DATA_W-1:0] i_cfg_rdata,
  // Something is still expected from the DUT
  output      logic                          o_busy
);

  import rr_pkg::*;

  int mismatch_errs = 0;
  int other_errs = 0;

  // Host view of the mode register
  logic        rec_en;
  logic        rply_en;
  // Log words the reference has asked for since reset
  int unsigned log_expected;

  // Expected outputs with the oldest first
  chan_a_req_t           exp_a[$];
  chan_b_req_t           exp_b[$];
  log_word_t             exp_log[$];
  logic [CFG_DATA_W-1:0] exp_rd[$];
  // Recorded shell sequence that replay brings back
  chan_a_req_t           saved_a[$];
  chan_b_req_t           saved_b[$];
  log_word_t             saved_log[$];

  chan_a_req_t           want_a;
  chan_b_req_t           want_b;
  log_word_t             want_log;
  logic [CFG_DATA_W-1:0] want_rd;

  function automatic string phase_name(input logic [2:0] ph);
    case (ph)
      3'd0:    return "reset_state";
      3'd1:    return "pass_through";
      3'd2:    return "recording";
      3'd3:    return "count_readback";
      3'd4:    return "replay";
      default: return "unknown_phase";
    endcase
  endfunction

  // Valid A at bit 81 and valid B at bit 80
  // Then the A payload in 79..32 and the B payload in 31..0
  // An idle channel contributes zeros
  function automatic log_word_t expected_log_word(
    input logic        a_vld,
    input chan_a_req_t a_req,
    input logic        b_vld,
    input chan_b_req_t b_req
  );
    logic [47:0] a_bits;
    logic [31:0] b_bits;
    a_bits = a_vld ? a_req : 48'h0;
    b_bits = b_vld ? b_req : 32'h0;
    return {a_vld, b_vld, a_bits, b_bits};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Per-cycle watch of the DUT ports
  //////////////////////////////////////////////////////////////////////

  always @(posedge i_clk) begin
    if (i_rst) begin
      rec_en       = 1'b0;
      rply_en      = 1'b0;
      log_expected = 0;
    end else begin
      // Read data reflects state before this edge
      if (i_cfg_re) begin
        if (i_cfg_addr == CFG_ADDR_MODE) begin
          exp_rd.push_back({30'h0, rply_en, rec_en});
        end else if (i_cfg_addr == CFG_ADDR_COUNT) begin
          exp_rd.push_back(log_expected);
        end else begin
          exp_rd.push_back('0);
        end
      end

      if ($isunknown({i_cl_a_valid, i_cl_b_valid, i_log_valid, i_cfg_rvalid})) begin
        other_errs++;
        $display("a valid output of the DUT is unknown in %s", phase_name(i_phase));
      end

      // Channel A at the user side
      if (i_cl_a_valid === 1'b1) begin
        if (exp_a.size() == 0) begin
          other_errs++;
          $display("unexpected channel A strobe at the user side in %s",
                   phase_name(i_phase));
        end else begin
          want_a = exp_a.pop_front();
          if (i_cl_a_req !== want_a) begin
            mismatch_errs++;
            $display("mismatch test=%s cl_a expected=%h actual=%h",
                     phase_name(i_phase), want_a, i_cl_a_req);
          end
        end
      end

      // Channel B at the user side
      if (i_cl_b_valid === 1'b1) begin
        if (exp_b.size() == 0) begin
          other_errs++;
          $display("unexpected channel B strobe at the user side in %s",
                   phase_name(i_phase));
        end else begin
          want_b = exp_b.pop_front();
          if (i_cl_b_req !== want_b) begin
            mismatch_errs++;
            $display("mismatch test=%s cl_b expected=%h actual=%h",
                     phase_name(i_phase), want_b, i_cl_b_req);
          end
        end
      end

      // Log stream
      if (i_log_valid === 1'b1) begin
        if (exp_log.size() == 0) begin
          other_errs++;
          $display("unexpected log word in %s", phase_name(i_phase));
        end else begin
          want_log = exp_log.pop_front();
          if (i_log_word !== want_log) begin
            mismatch_errs++;
            $display("mismatch test=%s log_word expected=%h actual=%h",
                     phase_name(i_phase), want_log, i_log_word);
          end
        end
      end

      // Config readback
      if (i_cfg_rvalid === 1'b1) begin
        if (exp_rd.size() == 0) begin
          other_errs++;
          $display("read data returned without a read in %s", phase_name(i_phase));
        end else begin
          want_rd = exp_rd.pop_front();
          if (i_cfg_rdata !== want_rd) begin
            mismatch_errs++;
            $display("mismatch test=%s cfg_rdata expected=%h actual=%h",
                     phase_name(i_phase), want_rd, i_cfg_rdata);
          end
        end
      end

      // Shell traffic counts only while live traffic is selected
      if (!rply_en) begin
        if (i_sh_a_valid) begin
          exp_a.push_back(i_sh_a_req);
        end
        if (i_sh_b_valid) begin
          exp_b.push_back(i_sh_b_req);
        end
        if (rec_en && (i_sh_a_valid || i_sh_b_valid)) begin
          want_log = expected_log_word(i_sh_a_valid, i_sh_a_req, i_sh_b_valid, i_sh_b_req);
          exp_log.push_back(want_log);
          saved_log.push_back(want_log);
          log_expected++;
          if (i_sh_a_valid) begin
            saved_a.push_back(i_sh_a_req);
          end
          if (i_sh_b_valid) begin
            saved_b.push_back(i_sh_b_req);
          end
        end
      end

      // Entering replay by a mode write brings back the recorded sequence
      if (i_cfg_we && (i_cfg_addr == CFG_ADDR_MODE)) begin
        if (i_cfg_wdata[1] && !rply_en) begin
          foreach (saved_a[i]) exp_a.push_back(saved_a[i]);
          foreach (saved_b[i]) exp_b.push_back(saved_b[i]);
          if (i_cfg_wdata[0]) begin
            foreach (saved_log[i]) exp_log.push_back(saved_log[i]);
            log_expected += saved_log.size();
          end
        end
        rec_en  = i_cfg_wdata[0];
        rply_en = i_cfg_wdata[1];
      end
    end

    o_busy = (exp_a.size() != 0) || (exp_b.size() != 0) ||
             (exp_log.size() != 0) || (exp_rd.size() != 0);
  end

  // Anything still queued at the end never arrived
  task automatic finish_checks();
    if (exp_a.size() != 0) begin
      other_errs++;
      $display("%0d channel A strobes never reached the user side", exp_a.size());
    end
    if (exp_b.size() != 0) begin
      other_errs++;
      $display("%0d channel B strobes never reached the user side", exp_b.size());
    end
    if (exp_log.size() != 0) begin
      other_errs++;
      $display("%0d expected log words never appeared", exp_log.size());
    end
    if (exp_rd.size() != 0) begin
      other_errs++;
      $display("%0d config reads got no read data", exp_rd.size());
    end
  endtask

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`default_nettype none

module tb_top;

  import rr_pkg::*;

  localparam int CLK_HALF      = 5;
  localparam int RESET_CYCLES  = 8;
  localparam int MODE_SETTLE   = 10;
  localparam int STIM_CYCLES   = 200;
  // Four phases of roughly 300 cycles with a generous margin
  localparam int PHASE_CYCLES  = 300;
  localparam int NUM_PHASES    = 4;
  localparam int TIMEOUT_CYCLES = NUM_PHASES * PHASE_CYCLES * 5 / 2;
  localparam logic [31:0] RAND_SEED = 32'h2d51525b;

  logic                  clk;
  logic                  rst;
  logic                  sh_a_valid;
  chan_a_req_t           sh_a_req;
  logic                  sh_b_valid;
  chan_b_req_t           sh_b_req;
  logic                  rply_valid;
  log_word_t             rply_word;
  logic                  cfg_we;
  logic                  cfg_re;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic                  cl_a_valid;
  chan_a_req_t           cl_a_req;
  logic                  cl_b_valid;
  chan_b_req_t           cl_b_req;
  logic                  log_valid;
  log_word_t             log_word;
  logic                  cfg_rvalid;
  logic [CFG_DATA_W-1:0] cfg_rdata;
  logic                  chk_busy;

  logic [2:0]  phase;
  logic        capture_en;
  log_word_t   saved_words[$];
  int          cycle_count = 0;
  int unsigned seed_val;
  int          idx;

  always #CLK_HALF clk = ~clk;

  rr_top dut0 (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_sh_a_valid (sh_a_valid),
    .i_sh_a_req   (sh_a_req),
    .i_sh_b_valid (sh_b_valid),
    .i_sh_b_req   (sh_b_req),
    .i_rply_valid (rply_valid),
    .i_rply_word  (rply_word),
    .i_cfg_we     (cfg_we),
    .i_cfg_re     (cfg_re),
    .i_cfg_addr   (cfg_addr),
    .i_cfg_wdata  (cfg_wdata),
    .o_cl_a_valid (cl_a_valid),
    .o_cl_a_req   (cl_a_req),
    .o_cl_b_valid (cl_b_valid),
    .o_cl_b_req   (cl_b_req),
    .o_log_valid  (log_valid),
    .o_log_word   (log_word),
    .o_cfg_rvalid (cfg_rvalid),
    .o_cfg_rdata  (cfg_rdata)
  );

  rr_checker chk0 (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_phase      (phase),
    .i_sh_a_valid (sh_a_valid),
    .i_sh_a_req   (sh_a_req),
    .i_sh_b_valid (sh_b_valid),
    .i_sh_b_req   (sh_b_req),
    .i_cfg_we     (cfg_we),
    .i_cfg_re     (cfg_re),
    .i_cfg_addr   (cfg_addr),
    .i_cfg_wdata  (cfg_wdata),
    .i_cl_a_valid (cl_a_valid),
    .i_cl_a_req   (cl_a_req),
    .i_cl_b_valid (cl_b_valid),
    .i_cl_b_req   (cl_b_req),
    .i_log_valid  (log_valid),
    .i_log_word   (log_word),
    .i_cfg_rvalid (cfg_rvalid),
    .i_cfg_rdata  (cfg_rdata),
    .o_busy       (chk_busy)
  );

  //////////////////////////////////////////////////////////////////////
  // Timeout and capture of recorded words
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("error counts: %0d mismatches, %0d other errors",
               chk0.mismatch_errs, chk0.other_errs + 1);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Recorded words become the replay stimulus
  always @(posedge clk) begin
    if (capture_en && (log_valid === 1'b1)) begin
      saved_words.push_back(log_word);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks driven on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    sh_a_valid = 1'b0;
    sh_a_req   = '0;
    sh_b_valid = 1'b0;
    sh_b_req   = '0;
    rply_valid = 1'b0;
    rply_word  = '0;
    cfg_we     = 1'b0;
    cfg_re     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
  endtask

  // Random strobes with random payloads even when idle
  task automatic drive_shell_random();
    sh_a_valid    = 1'($urandom % 2);
    sh_a_req.addr = CHAN_A_ADDR_W'($urandom);
    sh_a_req.data = $urandom;
    sh_b_valid    = 1'($urandom % 2);
    sh_b_req.data = $urandom;
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    // Let the mode pipeline settle
    repeat (MODE_SETTLE) @(negedge clk);
  endtask

  task automatic cfg_read(input logic [CFG_ADDR_W-1:0] addr);
    @(negedge clk);
    cfg_re   = 1'b1;
    cfg_addr = addr;
    @(negedge clk);
    cfg_re = 1'b0;
    while (cfg_rvalid !== 1'b1) @(negedge clk);
  endtask

  // Wait until the checker holds no outstanding expectations
  task automatic wait_drained();
    @(negedge clk);
    @(negedge clk);
    while (chk_busy) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed_val   = $urandom(RAND_SEED);
    clk        = 1'b0;
    rst        = 1'b1;
    phase      = 3'd0;
    capture_en = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    // Reset state with no traffic
    repeat (5) @(negedge clk);
    cfg_read(CFG_ADDR_MODE);
    cfg_read(CFG_ADDR_COUNT);
    repeat (10) @(negedge clk);

    // Pass-through with mode zero
    phase = 3'd1;
    repeat (STIM_CYCLES) begin
      @(negedge clk);
      drive_shell_random();
    end
    @(negedge clk);
    drive_idle();
    wait_drained();

    // Recording
    phase = 3'd2;
    cfg_write(CFG_ADDR_MODE, 32'h1);
    capture_en = 1'b1;
    repeat (STIM_CYCLES) begin
      @(negedge clk);
      drive_shell_random();
    end
    @(negedge clk);
    drive_idle();
    wait_drained();
    capture_en = 1'b0;

    // Count of words logged since reset
    phase = 3'd3;
    cfg_read(CFG_ADDR_COUNT);
    cfg_read(CFG_ADDR_MODE);

    // Replay with recording still on while shell traffic keeps running
    phase = 3'd4;
    cfg_write(CFG_ADDR_MODE, 32'h3);
    idx = 0;
    while (idx < saved_words.size()) begin
      @(negedge clk);
      drive_shell_random();
      if (($urandom % 4) != 0) begin
        rply_valid = 1'b1;
        rply_word  = saved_words[idx];
        idx++;
      end else begin
        // Idle cycle with a junk word on the bus
        rply_valid = 1'b0;
        rply_word  = {2'($urandom), CHAN_A_ADDR_W'($urandom), $urandom, $urandom};
      end
    end
    @(negedge clk);
    drive_idle();
    wait_drained();

    chk0.finish_checks();
    $display("error counts: %0d mismatches, %0d other errors",
             chk0.mismatch_errs, chk0.other_errs);
    if ((chk0.mismatch_errs == 0) && (chk0.other_errs == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
common/rr_pkg.sv
design/rr_mode_csr.sv
design/rr_chan_sel.sv
recorder/rr_log_packer.sv
replayer/rr_trace_decoder.sv
design/rr_top.sv
verif/rr_checker.sv
verif/tb_top.sv
